// File: wbu_config.svh
// widths assume an RV32 integer register file with 32 registers
// queue depth sets how many results one source may leave pending per port
`ifndef WBU_CONFIG_SVH
`define WBU_CONFIG_SVH

// one register word
`define REG_DATA_WIDTH 32

// register index, x0..x31
`define REG_ADDR_WIDTH 5

// commit identifier, wraps at 16 in-flight instructions
`define COMMIT_ID_WIDTH 4

// entries per buffered source queue
`define WB_QUEUE_DEPTH 2

`endif

// File: wbu_pkg.sv
// one payload type serves all sources, queue entries and port outputs
// on a port output, we also marks commit valid for commit_id
`default_nettype none

`include "wbu_config.svh"

package wbu_pkg;

    // a finished result headed for the register file
    typedef struct packed {
        logic                         we;
        logic [`REG_ADDR_WIDTH-1:0]   addr;
        logic [`REG_DATA_WIDTH-1:0]   data;
        logic [`COMMIT_ID_WIDTH-1:0]  commit_id;
    } wb_wr_t;

    // buffered sources per write port, index 0 wins
    localparam int NUM_QUEUED = 3;

    // selects one of the buffered sources of a port
    typedef logic [$clog2(NUM_QUEUED)-1:0] queued_idx_t;

endpackage

`default_nettype wire

// File: wb_queue.sv
// head_o is only meaningful while empty_o is low
// a push into a full queue is dropped unless a pop happens in the same cycle
`timescale 1ns/100ps
`default_nettype none

`include "wbu_config.svh"

module wb_queue #(
    parameter int DEPTH = `WB_QUEUE_DEPTH
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    push_i,
    input  wire wbu_pkg::wb_wr_t   entry_i,
    input  wire                    pop_i,
    output wbu_pkg::wb_wr_t        head_o,
    output logic                   empty_o,
    output logic                   full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    wbu_pkg::wb_wr_t  mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

    // full queue still takes a push when the head leaves in the same cycle
    assign do_push = push_i && (!full_o || pop_i);
    assign do_pop  = pop_i && !empty_o;

    assign head_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: wb_port_arbiter.sv
// direct source has no ready and always wins, so it must never stall
// buffered sources hold their request while their ready is low
`timescale 1ns/100ps
`default_nettype none

`include "wbu_config.svh"

module wb_port_arbiter (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire wbu_pkg::wb_wr_t                             direct_i,
    input  wire wbu_pkg::wb_wr_t [wbu_pkg::NUM_QUEUED-1:0]   queued_i,
    output logic [wbu_pkg::NUM_QUEUED-1:0]                   queued_ready_o,
    output wbu_pkg::wb_wr_t                                  wb_o
);

    localparam int NQ = wbu_pkg::NUM_QUEUED;

    wbu_pkg::wb_wr_t [NQ-1:0] q_head;
    logic [NQ-1:0]            q_empty;
    logic [NQ-1:0]            q_full;
    logic [NQ-1:0]            q_push;
    logic [NQ-1:0]            q_pop;
    logic [NQ-1:0]            q_byp;

    wbu_pkg::queued_idx_t     head_idx;
    logic                     head_found;
    wbu_pkg::queued_idx_t     byp_idx;
    logic                     byp_ok;
    wbu_pkg::wb_wr_t          sel;

    // output register, only we is control state
    logic                         wb_we_q;
    logic [`REG_ADDR_WIDTH-1:0]   wb_addr_q;
    logic [`REG_DATA_WIDTH-1:0]   wb_data_q;
    logic [`COMMIT_ID_WIDTH-1:0]  wb_cid_q;

    for (genvar g = 0; g < NQ; g++) begin : gen_queue
        wb_queue #(
            .DEPTH (`WB_QUEUE_DEPTH)
        ) q_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .push_i  (q_push[g]),
            .entry_i (queued_i[g]),
            .pop_i   (q_pop[g]),
            .head_o  (q_head[g]),
            .empty_o (q_empty[g]),
            .full_o  (q_full[g])
        );
    end

    assign queued_ready_o = ~q_full;

    // oldest pending work first, lowest index wins among queue heads
    always_comb begin
        head_found = 1'b0;
        head_idx   = '0;
        for (int i = NQ - 1; i >= 0; i--) begin
            if (!q_empty[i]) begin
                head_found = 1'b1;
                head_idx   = wbu_pkg::queued_idx_t'(i);
            end
        end
    end

    // bypass only onto a fully idle port, and only the top requester
    always_comb begin
        byp_ok  = 1'b0;
        byp_idx = '0;
        for (int i = NQ - 1; i >= 0; i--) begin
            if (queued_i[i].we) begin
                byp_ok  = 1'b1;
                byp_idx = wbu_pkg::queued_idx_t'(i);
            end
        end
        byp_ok = byp_ok && !direct_i.we && (&q_empty);
    end

    // accepted requests that do not go straight out are stored
    always_comb begin
        for (int i = 0; i < NQ; i++) begin
            q_byp[i]  = byp_ok && (byp_idx == wbu_pkg::queued_idx_t'(i));
            q_pop[i]  = !direct_i.we && head_found
                        && (head_idx == wbu_pkg::queued_idx_t'(i));
            q_push[i] = queued_i[i].we && !q_full[i] && !q_byp[i];
        end
    end

    always_comb begin
        if (direct_i.we) begin
            sel = direct_i;
        end else if (head_found) begin
            sel = q_head[head_idx];
        end else if (byp_ok) begin
            sel = queued_i[byp_idx];
        end else begin
            sel = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we_q <= 1'b0;
        end else begin
            wb_we_q <= sel.we;
        end
    end

    // payload only loads with a real write
    always_ff @(posedge clk) begin
        if (sel.we) begin
            wb_addr_q <= sel.addr;
            wb_data_q <= sel.data;
            wb_cid_q  <= sel.commit_id;
        end
    end

    always_comb begin
        wb_o.we        = wb_we_q;
        wb_o.addr      = wb_addr_q;
        wb_o.data      = wb_data_q;
        wb_o.commit_id = wb_cid_q;
    end

endmodule

`default_nettype wire

// File: wbu_top.sv
// port 1 takes mul1 direct, then div1, alu1, csr
// port 2 takes lsu direct, then mul2, div2, alu2
`timescale 1ns/100ps
`default_nettype none

module wbu_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire wbu_pkg::wb_wr_t   mul1_i,
    input  wire wbu_pkg::wb_wr_t   div1_i,
    input  wire wbu_pkg::wb_wr_t   alu1_i,
    input  wire wbu_pkg::wb_wr_t   csr_i,
    input  wire wbu_pkg::wb_wr_t   lsu_i,
    input  wire wbu_pkg::wb_wr_t   mul2_i,
    input  wire wbu_pkg::wb_wr_t   div2_i,
    input  wire wbu_pkg::wb_wr_t   alu2_i,
    output logic                   div1_ready_o,
    output logic                   alu1_ready_o,
    output logic                   csr_ready_o,
    output logic                   mul2_ready_o,
    output logic                   div2_ready_o,
    output logic                   alu2_ready_o,
    output wbu_pkg::wb_wr_t        wb1_o,
    output wbu_pkg::wb_wr_t        wb2_o
);

    logic [wbu_pkg::NUM_QUEUED-1:0] port1_ready;
    logic [wbu_pkg::NUM_QUEUED-1:0] port2_ready;

    // index 0 sits at the right end of each concatenation
    wb_port_arbiter port1_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .direct_i       (mul1_i),
        .queued_i       ({csr_i, alu1_i, div1_i}),
        .queued_ready_o (port1_ready),
        .wb_o           (wb1_o)
    );

    wb_port_arbiter port2_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .direct_i       (lsu_i),
        .queued_i       ({alu2_i, div2_i, mul2_i}),
        .queued_ready_o (port2_ready),
        .wb_o           (wb2_o)
    );

    assign div1_ready_o = port1_ready[0];
    assign alu1_ready_o = port1_ready[1];
    assign csr_ready_o  = port1_ready[2];

    assign mul2_ready_o = port2_ready[0];
    assign div2_ready_o = port2_ready[1];
    assign alu2_ready_o = port2_ready[2];

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// free-running clock, reset held low for the first 3 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter realtime PERIOD = 8.0
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

    always #(PERIOD / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// File: wbu_assertions.sv
// watches top-level ports only
// ready check covers the highest-priority queue of port 1
`timescale 1ns/100ps
`default_nettype none

module wbu_assertions (
    input wire                  clk,
    input wire                  rst_n,
    input wire wbu_pkg::wb_wr_t mul1_i,
    input wire wbu_pkg::wb_wr_t lsu_i,
    input wire                  div1_ready_o,
    input wire wbu_pkg::wb_wr_t wb1_o,
    input wire wbu_pkg::wb_wr_t wb2_o
);

    // no register writes while in reset
    assert property (@(posedge clk) !rst_n |-> !wb1_o.we && !wb2_o.we)
        else $error("port output write enable high during reset");

    // direct writes leave one cycle later with their own commit id
    assert property (@(posedge clk) disable iff (!rst_n)
        mul1_i.we |=> wb1_o.we && (wb1_o.commit_id == $past(mul1_i.commit_id)))
        else $error("mul1 direct write did not reach port 1 in one cycle");

    assert property (@(posedge clk) disable iff (!rst_n)
        lsu_i.we |=> wb2_o.we && (wb2_o.commit_id == $past(lsu_i.commit_id)))
        else $error("lsu direct write did not reach port 2 in one cycle");

    // top queue only pops when the direct source is idle
    assert property (@(posedge clk) disable iff (!rst_n)
        !div1_ready_o && mul1_i.we |=> !div1_ready_o)
        else $error("div1 ready rose while its full queue could not drain");

endmodule

`default_nettype wire

// File: wbu_tb.sv
// directed tests for the write-back unit
// a monitor pairs every port output write with the expected result queue
`timescale 1ns/100ps
`default_nettype none

`include "wbu_config.svh"

module wbu_tb;

    localparam realtime CLK_PERIOD = 8.0;
    localparam int      RUN_CYCLES = 200;

    logic clk;
    logic rst_n;

    wbu_pkg::wb_wr_t mul1_i, div1_i, alu1_i, csr_i;
    wbu_pkg::wb_wr_t lsu_i, mul2_i, div2_i, alu2_i;
    logic div1_ready_o, alu1_ready_o, csr_ready_o;
    logic mul2_ready_o, div2_ready_o, alu2_ready_o;
    wbu_pkg::wb_wr_t wb1_o, wb2_o;

    wbu_pkg::wb_wr_t exp1[$];
    wbu_pkg::wb_wr_t exp2[$];
    logic [`COMMIT_ID_WIDTH-1:0] next_cid;

    tb_clk_gen #(.PERIOD(CLK_PERIOD)) clk_gen_inst (.clk(clk), .rst_n(rst_n));

    wbu_top wbu_top_inst (.*);

    bind wbu_top wbu_assertions assertions_inst (
        .clk(clk), .rst_n(rst_n), .mul1_i(mul1_i), .lsu_i(lsu_i),
        .div1_ready_o(div1_ready_o),
        .wb1_o(wb1_o), .wb2_o(wb2_o)
    );

    task automatic fail_now(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // an idle write only has to show we low
    task automatic check_wr(input wbu_pkg::wb_wr_t exp, input wbu_pkg::wb_wr_t act,
                            input string what);
        if (exp.we ? (act !== exp) : (act.we !== 1'b0)) begin
            fail_now($sformatf("%s expected %h got %h", what, exp, act));
        end
    endtask

    task automatic check_ready(input logic exp, input logic act, input string what);
        if (act !== exp) begin
            fail_now($sformatf("%s ready expected %b got %b", what, exp, act));
        end
    endtask

    task automatic check_count(input int exp, input int act, input string what);
        if (act != exp) begin
            fail_now($sformatf("%s expected %0d got %0d", what, exp, act));
        end
    endtask

    function automatic wbu_pkg::wb_wr_t make_wr();
        wbu_pkg::wb_wr_t w;
        w.we        = 1'b1;
        w.addr      = $urandom;
        w.data      = $urandom;
        w.commit_id = next_cid;
        next_cid    = next_cid + 1'b1;
        return w;
    endfunction

    task automatic idle_inputs();
        mul1_i <= '0;
        div1_i <= '0;
        alu1_i <= '0;
        csr_i  <= '0;
        lsu_i  <= '0;
        mul2_i <= '0;
        div2_i <= '0;
        alu2_i <= '0;
    endtask

    // every write seen on a port must be the next one expected there
    always @(negedge clk) begin
        if (rst_n && wb1_o.we) begin
            if (exp1.size() == 0) begin
                fail_now("unexpected write on port 1");
            end else begin
                check_wr(exp1.pop_front(), wb1_o, "port 1");
            end
        end
        if (rst_n && wb2_o.we) begin
            if (exp2.size() == 0) begin
                fail_now("unexpected write on port 2");
            end else begin
                check_wr(exp2.pop_front(), wb2_o, "port 2");
            end
        end
    end

    task automatic wait_drained();
        while (exp1.size() != 0 || exp2.size() != 0) @(posedge clk);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_wr('0, wb1_o, "port 1 after reset");
        check_wr('0, wb2_o, "port 2 after reset");
        check_ready(1'b1, div1_ready_o, "div1");
        check_ready(1'b1, alu1_ready_o, "alu1");
        check_ready(1'b1, csr_ready_o, "csr");
        check_ready(1'b1, mul2_ready_o, "mul2");
        check_ready(1'b1, div2_ready_o, "div2");
        check_ready(1'b1, alu2_ready_o, "alu2");
    endtask

    task automatic test_direct();
        wbu_pkg::wb_wr_t a;
        wbu_pkg::wb_wr_t b;
        a = make_wr();
        b = make_wr();
        exp1.push_back(a);
        exp2.push_back(b);
        @(posedge clk);
        mul1_i <= a;
        lsu_i  <= b;
        @(posedge clk);
        idle_inputs();
        @(posedge clk);
        check_count(0, exp1.size() + exp2.size(), "direct writes still pending");
    endtask

    task automatic test_bypass();
        wbu_pkg::wb_wr_t a;
        wbu_pkg::wb_wr_t b;
        a = make_wr();
        b = make_wr();
        exp1.push_back(a);
        exp2.push_back(b);
        @(posedge clk);
        alu1_i <= a;
        @(posedge clk);
        idle_inputs();
        @(posedge clk);
        check_count(0, exp1.size(), "alu1 bypass still pending");
        div2_i <= b;
        @(posedge clk);
        idle_inputs();
        @(posedge clk);
        check_count(0, exp2.size(), "div2 bypass still pending");
    endtask

    // all sources of both ports write in one cycle
    task automatic test_priority();
        wbu_pkg::wb_wr_t w[8];
        foreach (w[i]) w[i] = make_wr();
        for (int i = 0; i < 4; i++) begin
            exp1.push_back(w[i]);
            exp2.push_back(w[i + 4]);
        end
        @(posedge clk);
        mul1_i <= w[0];
        div1_i <= w[1];
        alu1_i <= w[2];
        csr_i  <= w[3];
        lsu_i  <= w[4];
        mul2_i <= w[5];
        div2_i <= w[6];
        alu2_i <= w[7];
        @(posedge clk);
        idle_inputs();
        repeat (4) @(posedge clk);
        check_count(0, exp1.size() + exp2.size(), "priority results still pending");
    endtask

    task automatic test_backpressure();
        wbu_pkg::wb_wr_t m[6];
        wbu_pkg::wb_wr_t d[3];
        int              sent;
        bit              saw_low;
        foreach (m[i]) m[i] = make_wr();
        foreach (d[i]) d[i] = make_wr();
        foreach (m[i]) exp1.push_back(m[i]);
        foreach (d[i]) exp1.push_back(d[i]);
        sent    = 0;
        saw_low = 1'b0;
        for (int cyc = 0; sent < 3; cyc++) begin
            @(posedge clk);
            mul1_i <= (cyc < 6) ? m[cyc] : '0;
            div1_i <= d[sent];
            @(negedge clk);
            if (div1_ready_o) begin
                sent++;
            end else begin
                saw_low = 1'b1;
                check_count(2, sent, "div1 results accepted before stall");
            end
        end
        @(posedge clk);
        idle_inputs();
        check_count(1, saw_low, "div1 ready stalls");
        wait_drained();
    endtask

    // unique commit ids expose any result leaking onto the other port
    task automatic test_independence();
        wbu_pkg::wb_wr_t w[5];
        foreach (w[i]) w[i] = make_wr();
        exp1.push_back(w[0]);
        exp1.push_back(w[1]);
        exp2.push_back(w[2]);
        exp2.push_back(w[3]);
        exp2.push_back(w[4]);
        @(posedge clk);
        mul1_i <= w[0];
        alu1_i <= w[1];
        lsu_i  <= w[2];
        div2_i <= w[3];
        alu2_i <= w[4];
        @(posedge clk);
        idle_inputs();
        wait_drained();
    endtask

    initial begin
        void'($urandom(32'h5986b735));
        next_cid = '0;
        mul1_i = '0;
        div1_i = '0;
        alu1_i = '0;
        csr_i  = '0;
        lsu_i  = '0;
        mul2_i = '0;
        div2_i = '0;
        alu2_i = '0;
        @(posedge rst_n);
        test_reset();
        test_direct();
        test_bypass();
        test_priority();
        test_backpressure();
        test_independence();
        repeat (2) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
wbu_pkg.sv
wb_queue.sv
wb_port_arbiter.sv
wbu_top.sv
tb_clk_gen.sv
wbu_assertions.sv
wbu_tb.sv

// File: Bender.yml
package:
  name: wbu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - wbu_pkg.sv
      - wb_queue.sv
      - wb_port_arbiter.sv
      - wbu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - wbu_assertions.sv
      - wbu_tb.sv
